/* rtl/game_rom_params.svh */
// Game ROM parameters, SDRAM layout, PROM start and slot address widths
`ifndef GAME_ROM_PARAMS_SVH
`define GAME_ROM_PARAMS_SVH

// SDRAM word address width, 16-bit words
`define SDRAM_AW    22

// Graphics ROM follows the main ROM in SDRAM, in 16-bit words
`define GFX_OFFSET  22'h1_0000

// Download byte address where the palette PROMs begin
`define PROM_START  25'h6_0000

// Graphics slot address, 16-bit units
`define GFX_AW      17

// Main CPU slot address, bytes
`define MAIN_AW     17

`endif

/* rtl/sdram_pkg.sv */
// SDRAM read side types, slot line requests, read response and controller enums
`include "game_rom_params.svh"

package sdram_pkg;

    // Slot to controller, one 32-bit line per request
    typedef struct packed {
        logic                 req;        // Level, high while the line misses
        logic [`SDRAM_AW-1:0] line_addr;  // Even-aligned word address
    } line_req_t;

    // Controller to slots
    typedef struct packed {
        logic        capture;  // Pulse, data valid
        logic [31:0] data;
    } rd_resp_t;

    // Owner of the open transaction
    typedef enum logic [1:0] {
        SEL_NONE,
        SEL_GFX,
        SEL_MAIN
    } slot_sel_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_ACK,
        ST_WAIT_RDY
    } req_state_e;

endpackage

/* rtl/prog_pkg.sv */
// Download side types, loader byte stream and SDRAM programming write
`include "game_rom_params.svh"

package prog_pkg;

    // Loader byte stream
    typedef struct packed {
        logic [24:0] addr;   // Byte address
        logic [ 7:0] data;
        logic        wr;     // One cycle per byte
    } ioctl_t;

    // SDRAM byte write
    typedef struct packed {
        logic [`SDRAM_AW-1:0] addr;   // Word address, or PROM index
        logic [ 7:0]          data;
        logic [ 1:0]          mask;   // Active low, bit 1 is the upper byte
        logic                 we;     // Held until sdram_ack
    } prog_t;

endpackage

/* rtl/rom_slot.sv */
// ROM read slot, keeps one 32-bit SDRAM line and serves data lanes out of it
`include "game_rom_params.svh"

module rom_slot #(
    parameter int                   AW     = 17,
    parameter int                   DW     = 8,     // 8 or 16
    parameter logic [`SDRAM_AW-1:0] OFFSET = '0     // SDRAM word address of the region
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cs,
    input  logic [AW-1:0]        addr,
    output logic [DW-1:0]        dout,
    output logic                 ok,
    output sdram_pkg::line_req_t line_req,
    input  logic                 grant,
    input  sdram_pkg::rd_resp_t  resp,
    input  logic                 flush
);

    localparam int SAW    = `SDRAM_AW;
    localparam int LANES  = 32 / DW;
    localparam int LSB_W  = $clog2(LANES);      // Lane select bits in addr
    localparam int WSHIFT = (DW == 8) ? 1 : 0;  // Bytes to 16-bit words

    logic [SAW-1:0]   word_addr;
    logic [SAW-1:0]   line_addr;
    logic [SAW-1:0]   tag;
    logic             valid;
    logic [31:0]      line_data;
    logic [LSB_W-1:0] lane;
    logic             hit;
    logic             load;

    // Address of the line that holds the requested data
    always_comb begin
        word_addr    = SAW'(addr >> WSHIFT);
        line_addr    = OFFSET + word_addr;
        line_addr[0] = 1'b0;   // Lines are two words long
    end

    assign lane = addr[LSB_W-1:0];   // Lower address, lower bits
    assign hit  = valid && (tag == line_addr);
    assign load = grant && resp.capture;

    // Hit is served in the same cycle
    assign ok   = cs && hit;
    assign dout = line_data[lane*DW +: DW];

    always_comb begin
        line_req.req       = cs && !hit;
        line_req.line_addr = line_addr;
    end

    // Line valid, cleared on flush
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;
        end
    end

    // Line contents and tag
    always_ff @(posedge clk) begin
        if (load) begin
            tag       <= line_addr;   // Requester holds addr until ok
            line_data <= resp.data;
        end
    end

endmodule

/* rtl/rom_req_ctrl.sv */
// ROM request controller, arbitrates slot line misses onto the SDRAM read port
`include "game_rom_params.svh"

module rom_req_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 downloading,
    // Slots
    input  sdram_pkg::line_req_t gfx_req,
    input  sdram_pkg::line_req_t main_req,
    output logic                 gfx_grant,
    output logic                 main_grant,
    output sdram_pkg::rd_resp_t  resp,
    output logic                 flush,
    // SDRAM read port
    output logic                 sdram_req,
    output logic [`SDRAM_AW-1:0] sdram_addr,
    input  logic                 sdram_ack,
    input  logic                 data_dst,
    input  logic                 data_rdy,
    input  logic [31:0]          data_read
);

    import sdram_pkg::*;

    req_state_e           state;
    slot_sel_e            sel;
    slot_sel_e            next_sel;
    logic [`SDRAM_AW-1:0] next_addr;
    logic                 start;
    logic                 dwn_l;

    // Graphics wins when both slots miss
    always_comb begin
        if (gfx_req.req) begin
            next_sel  = SEL_GFX;
            next_addr = gfx_req.line_addr;
        end else begin
            next_sel  = SEL_MAIN;
            next_addr = main_req.line_addr;
        end
    end

    // New requests are held off during a download
    assign start = (state == ST_IDLE) && !downloading && (gfx_req.req || main_req.req);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            sel       <= SEL_NONE;
            sdram_req <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        sel       <= next_sel;
                        sdram_req <= 1'b1;
                        state     <= ST_WAIT_ACK;
                    end
                end
                ST_WAIT_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;   // Request accepted
                        state     <= ST_WAIT_RDY;
                    end
                end
                ST_WAIT_RDY: begin
                    if (data_rdy) begin
                        sel   <= SEL_NONE;
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    sel       <= SEL_NONE;
                    sdram_req <= 1'b0;
                    state     <= ST_IDLE;
                end
            endcase
        end
    end

    // Address stays put until the ack
    always_ff @(posedge clk) begin
        if (start) begin
            sdram_addr <= next_addr;
        end
    end

    assign gfx_grant  = (sel == SEL_GFX);
    assign main_grant = (sel == SEL_MAIN);

    // Data is broadcast, only the granted slot takes it
    always_comb begin
        resp.capture = data_dst && (sel != SEL_NONE);
        resp.data    = data_read;
    end

    // Invalidate all lines once the download is over
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dwn_l <= 1'b0;
            flush <= 1'b0;
        end else begin
            dwn_l <= downloading;
            flush <= dwn_l && !downloading;
        end
    end

endmodule

/* rtl/rom_dwnld.sv */
// ROM download, loader bytes become SDRAM byte writes or palette PROM strobes
`include "game_rom_params.svh"

module rom_dwnld (
    input  logic             clk,
    input  logic             rst_n,
    input  prog_pkg::ioctl_t ioctl,
    output prog_pkg::prog_t  prog,
    output logic             prom_we,
    input  logic             sdram_ack
);

    import prog_pkg::*;

    localparam logic [24:0] PROM_BASE = `PROM_START;

    prog_t       prog_q;
    logic        is_prom;
    logic [24:0] prom_off;

    always_comb begin
        is_prom  = ioctl.addr >= PROM_BASE;
        prom_off = ioctl.addr - PROM_BASE;
    end

    // One register stage behind ioctl
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog_q.we <= 1'b0;
            prom_we   <= 1'b0;
        end else begin
            prom_we <= ioctl.wr && is_prom;   // Single cycle strobe
            if (sdram_ack) begin
                prog_q.we <= 1'b0;
            end
            if (ioctl.wr) begin
                prog_q.data <= ioctl.data;
                if (is_prom) begin
                    // PROMs take a byte index from their own base
                    prog_q.addr <= prom_off[`SDRAM_AW-1:0];
                    prog_q.mask <= 2'b11;
                end else begin
                    prog_q.addr <= ioctl.addr[`SDRAM_AW:1];        // Byte to word
                    prog_q.mask <= ioctl.addr[0] ? 2'b01 : 2'b10;  // Odd is upper
                    prog_q.we   <= 1'b1;
                end
            end
        end
    end

    assign prog = prog_q;

endmodule

/* rtl/game_rom.sv */
// Game ROM access path, two read slots, SDRAM request control and download
`include "game_rom_params.svh"

module game_rom (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 downloading,
    // ROM load
    input  prog_pkg::ioctl_t     ioctl,
    output prog_pkg::prog_t      prog,
    output logic                 prom_we,
    // Graphics ROM
    input  logic                 gfx_cs,
    input  logic [`GFX_AW-1:0]   gfx_addr,
    output logic [15:0]          gfx_data,
    output logic                 gfx_ok,
    // Main CPU ROM
    input  logic                 main_cs,
    input  logic [`MAIN_AW-1:0]  main_addr,
    output logic [ 7:0]          main_data,
    output logic                 main_ok,
    // SDRAM read port
    output logic                 sdram_req,
    output logic [`SDRAM_AW-1:0] sdram_addr,
    input  logic                 sdram_ack,
    input  logic                 data_dst,
    input  logic                 data_rdy,
    input  logic [31:0]          data_read
);

    import sdram_pkg::*;

    line_req_t gfx_line_req;
    line_req_t main_line_req;
    rd_resp_t  resp;
    logic      gfx_grant;
    logic      main_grant;
    logic      flush;

    rom_slot #(
        .AW         ( `GFX_AW       ),
        .DW         ( 16            ),
        .OFFSET     ( `GFX_OFFSET   )
    ) u_gfx (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .cs         ( gfx_cs        ),
        .addr       ( gfx_addr      ),
        .dout       ( gfx_data      ),
        .ok         ( gfx_ok        ),
        .line_req   ( gfx_line_req  ),
        .grant      ( gfx_grant     ),
        .resp       ( resp          ),
        .flush      ( flush         )
    );

    rom_slot #(
        .AW         ( `MAIN_AW      ),
        .DW         ( 8             ),
        .OFFSET     ( '0            )   // Main ROM at the bottom
    ) u_main (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .cs         ( main_cs       ),
        .addr       ( main_addr     ),
        .dout       ( main_data     ),
        .ok         ( main_ok       ),
        .line_req   ( main_line_req ),
        .grant      ( main_grant    ),
        .resp       ( resp          ),
        .flush      ( flush         )
    );

    rom_req_ctrl u_ctrl (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .downloading( downloading   ),
        .gfx_req    ( gfx_line_req  ),
        .main_req   ( main_line_req ),
        .gfx_grant  ( gfx_grant     ),
        .main_grant ( main_grant    ),
        .resp       ( resp          ),
        .flush      ( flush         ),
        .sdram_req  ( sdram_req     ),
        .sdram_addr ( sdram_addr    ),
        .sdram_ack  ( sdram_ack     ),
        .data_dst   ( data_dst      ),
        .data_rdy   ( data_rdy      ),
        .data_read  ( data_read     )
    );

    rom_dwnld u_dwnld (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .ioctl      ( ioctl         ),
        .prog       ( prog          ),
        .prom_we    ( prom_we       ),
        .sdram_ack  ( sdram_ack     )
    );

endmodule

/* verification/game_rom_sva.sv */
// Game ROM assertions, download writes, slot data and SDRAM read port rules
`include "game_rom_params.svh"

module game_rom_sva (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 downloading,
    input prog_pkg::ioctl_t     ioctl,
    input prog_pkg::prog_t      prog,
    input logic                 prom_we,
    input logic                 gfx_cs,
    input logic [`GFX_AW-1:0]   gfx_addr,
    input logic [15:0]          gfx_data,
    input logic                 gfx_ok,
    input logic [`MAIN_AW-1:0]  main_addr,
    input logic [ 7:0]          main_data,
    input logic                 main_ok,
    input logic                 sdram_req,
    input logic [`SDRAM_AW-1:0] sdram_addr,
    input logic                 sdram_ack
);

    int fail_cnt = 0;

    // Stored word is the low address bits XOR 5a5a
    function automatic logic [15:0] model_word(input logic [`SDRAM_AW-1:0] w);
        return w[15:0] ^ 16'h5a5a;
    endfunction

    function automatic logic [7:0] model_byte(input logic [`MAIN_AW-1:0] b);
        logic [15:0] word;
        word = model_word(`SDRAM_AW'(b >> 1));
        return b[0] ? word[15:8] : word[7:0];   // Odd byte is the upper half
    endfunction

    function automatic logic [`SDRAM_AW-1:0] gfx_line(input logic [`GFX_AW-1:0] g);
        return (`GFX_OFFSET + g) & ~`SDRAM_AW'(1);
    endfunction

    a_reset: assert property (@(posedge clk) !rst_n |=> !sdram_req && !prog.we && !prom_we
        && !main_ok && !gfx_ok)
        else begin
            $error("outputs active after reset");
            fail_cnt++;
        end

    a_prog_write: assert property (@(posedge clk) disable iff (!rst_n)
        ioctl.wr && ioctl.addr < `PROM_START |=> prog.we && prog.addr == $past(ioctl.addr[22:1])
        && prog.data == $past(ioctl.data) && prog.mask == ($past(ioctl.addr[0]) ? 2'b01 : 2'b10))
        else begin
            $error("prog write fields wrong");
            fail_cnt++;
        end

    a_prog_hold: assert property (@(posedge clk) disable iff (!rst_n)
        prog.we && !sdram_ack |=> prog.we)
        else begin
            $error("prog we dropped before ack");
            fail_cnt++;
        end

    a_prom_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        ioctl.wr && ioctl.addr >= `PROM_START |=> prom_we && !prog.we)
        else begin
            $error("PROM byte gave no prom_we or a prog we");
            fail_cnt++;
        end

    a_prom_src: assert property (@(posedge clk) disable iff (!rst_n)
        prom_we |-> $past(ioctl.wr) && $past(ioctl.addr) >= `PROM_START)
        else begin
            $error("prom_we without a PROM byte");
            fail_cnt++;
        end

    a_main_data: assert property (@(posedge clk) disable iff (!rst_n)
        main_ok |-> main_data == model_byte(main_addr))
        else begin
            $error("main_data differs from SDRAM contents");
            fail_cnt++;
        end

    a_gfx_data: assert property (@(posedge clk) disable iff (!rst_n)
        gfx_ok |-> gfx_data == model_word(`GFX_OFFSET + gfx_addr))
        else begin
            $error("gfx_data differs from SDRAM contents");
            fail_cnt++;
        end

    // Graphics miss wins the port
    a_gfx_first: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sdram_req) && $past(gfx_cs && !gfx_ok) |-> sdram_addr == gfx_line($past(gfx_addr)))
        else begin
            $error("graphics miss not served first");
            fail_cnt++;
        end

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else begin
            $error("sdram_req or sdram_addr moved before ack");
            fail_cnt++;
        end

    a_no_req_dl: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sdram_req) |-> !$past(downloading))
        else begin
            $error("read started during download");
            fail_cnt++;
        end

endmodule

/* verification/tb_game_rom.sv */
// Game ROM testbench, SDRAM model with random timing, download and slot read tests
`include "game_rom_params.svh"

module tb_game_rom;

    import prog_pkg::*;

    localparam int PERIOD  = 20;
    localparam int TIMEOUT = 200;   // Cycles allowed per wait

    logic                 clk;
    logic                 rst_n;
    logic                 downloading;
    ioctl_t               ioctl;
    prog_t                prog;
    logic                 prom_we;
    logic                 gfx_cs;
    logic [`GFX_AW-1:0]   gfx_addr;
    logic [15:0]          gfx_data;
    logic                 gfx_ok;
    logic                 main_cs;
    logic [`MAIN_AW-1:0]  main_addr;
    logic [ 7:0]          main_data;
    logic                 main_ok;
    logic                 sdram_req;
    logic [`SDRAM_AW-1:0] sdram_addr;
    logic                 sdram_ack;
    logic                 data_dst;
    logic                 data_rdy;
    logic [31:0]          data_read;
    logic [31:0]          lfsr = 32'hbc5c_795b;
    logic [`SDRAM_AW-1:0] rd_addrs[$];   // Every read the model served
    int                   errors = 0;
    int                   tests = 0;
    int                   failed_tests = 0;
    int                   test_start = 0;

    game_rom u_dut (.*);

    bind game_rom game_rom_sva u_sva (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(PERIOD * 20000);
        $display("Simulation did not reach the end in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);   // One step per bit
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [15:0] model_word(input logic [`SDRAM_AW-1:0] w);
        return w[15:0] ^ 16'h5a5a;
    endfunction

    function automatic logic [7:0] model_byte(input logic [`MAIN_AW-1:0] b);
        logic [15:0] word;
        word = model_word(`SDRAM_AW'(b >> 1));
        return b[0] ? word[15:8] : word[7:0];
    endfunction

    function automatic int total_errors();
        return errors + u_dut.u_sva.fail_cnt;
    endfunction

    task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH t=%0t %s expected %0h actual %0h", $time, sig, exp, act);
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("t=%0t %s", $time, what);
        errors++;
    endtask

    task automatic begin_test();
        test_start = total_errors();
    endtask

    task automatic end_test(input string name);
        tests++;
        if (total_errors() != test_start) begin
            failed_tests++;
        end
        $display("test %0d %-20s %s", tests, name, (total_errors() == test_start) ? "ok" : "bad");
    endtask

    // SDRAM controller model, serves prog writes and line reads
    always begin : sdram_model
        logic [31:0]          r;
        logic [`SDRAM_AW-1:0] a;
        @(negedge clk);
        if (rst_n && prog.we) begin
            take_bits(2, r);
            repeat (r) @(negedge clk);
            sdram_ack = 1'b1;
            @(negedge clk);
            sdram_ack = 1'b0;
        end else if (rst_n && sdram_req) begin
            a = sdram_addr;
            rd_addrs.push_back(a);
            take_bits(2, r);
            repeat (r) @(negedge clk);   // Back-pressure on sdram_req
            sdram_ack = 1'b1;
            @(negedge clk);
            sdram_ack = 1'b0;
            take_bits(2, r);
            repeat (r) @(negedge clk);
            data_read = {model_word(a + 1'b1), model_word(a)};
            data_dst  = 1'b1;
            @(negedge clk);
            data_dst  = 1'b0;
            take_bits(1, r);
            repeat (r) @(negedge clk);
            data_rdy  = 1'b1;
            @(negedge clk);
            data_rdy  = 1'b0;
        end
    end

    task automatic load_byte(input logic [24:0] a, input logic [7:0] d);
        int n;
        @(negedge clk);
        ioctl.addr = a;
        ioctl.data = d;
        ioctl.wr   = 1'b1;
        @(negedge clk);
        ioctl.wr   = 1'b0;
        #2;
        if (a < `PROM_START) begin
            check_value("prog.we", 1, prog.we);
            check_value("prog.addr", a >> 1, prog.addr);
            check_value("prog.data", d, prog.data);
            check_value("prog.mask", a[0] ? 2'b01 : 2'b10, prog.mask);
            n = 0;
            while (prog.we && n < TIMEOUT) begin
                @(negedge clk);
                #2;
                n++;
            end
            if (prog.we) report_failure("prog.we never released by sdram_ack");
        end else begin
            check_value("prom_we", 1, prom_we);
            check_value("prog.we", 0, prog.we);
            @(negedge clk);
            #2;
            check_value("prom_we", 0, prom_we);   // Single pulse
        end
    endtask

    function automatic logic slot_ok(input bit is_gfx);
        return is_gfx ? gfx_ok : main_ok;
    endfunction

    task automatic read_slot(input bit is_gfx, input logic [16:0] a, output int lat);
        @(negedge clk);
        if (is_gfx) begin
            gfx_cs   = 1'b1;
            gfx_addr = a;
        end else begin
            main_cs   = 1'b1;
            main_addr = a;
        end
        #2;
        lat = 0;
        while (!slot_ok(is_gfx) && lat < TIMEOUT) begin
            @(negedge clk);
            #2;
            lat++;
        end
        if (!slot_ok(is_gfx)) begin
            report_failure(is_gfx ? "timeout waiting for gfx_ok" : "timeout waiting for main_ok");
        end else if (is_gfx) begin
            check_value("gfx_data", model_word(`GFX_OFFSET + a), gfx_data);
        end else begin
            check_value("main_data", model_byte(a), main_data);
        end
        @(negedge clk);
        gfx_cs  = 1'b0;
        main_cs = 1'b0;
    endtask

    initial begin : stimulus
        logic [31:0]          ra;
        logic [31:0]          rd;
        logic [16:0]          m;
        logic [16:0]          g;
        logic [`SDRAM_AW-1:0] exp_line;
        int                   lat;
        int                   n0;
        int                   n;
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl       = '0;
        gfx_cs      = 1'b0;
        gfx_addr    = '0;
        main_cs     = 1'b0;
        main_addr   = '0;
        sdram_ack   = 1'b0;
        data_dst    = 1'b0;
        data_rdy    = 1'b0;
        data_read   = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        begin_test();
        downloading = 1'b1;
        load_byte(25'h0_1235, 8'ha7);   // Odd, upper lane
        load_byte(25'h0_1236, 8'h3c);
        take_bits(18, ra);
        take_bits(8, rd);
        load_byte(25'(ra[17:0]), rd[7:0]);
        end_test("download writes");

        begin_test();
        load_byte(`PROM_START + 25'h5, 8'h0f);
        take_bits(8, ra);
        load_byte(`PROM_START + 25'(ra[7:0]), 8'hf0);
        @(negedge clk);
        downloading = 1'b0;
        end_test("prom writes");

        begin_test();
        for (int i = 0; i < 4; i++) begin
            take_bits(17, ra);
            m = ra[16:0];
            read_slot(1'b0, m, lat);
            n0 = rd_addrs.size();
            read_slot(1'b0, m ^ 17'h3, lat);   // Same line
            if (lat != 0 || rd_addrs.size() != n0) report_failure("main same-line read missed");
        end
        end_test("main slot");

        begin_test();
        for (int i = 0; i < 3; i++) begin
            take_bits(17, ra);
            g  = ra[16:0];
            n0 = rd_addrs.size();
            read_slot(1'b1, g, lat);
            exp_line = (`GFX_OFFSET + g) & ~`SDRAM_AW'(1);
            if (rd_addrs.size() > n0) check_value("sdram_addr", exp_line, rd_addrs[$]);
        end
        end_test("graphics slot");

        begin_test();
        g  = g ^ 17'h100;
        m  = m ^ 17'h100;
        n0 = rd_addrs.size();
        @(negedge clk);
        gfx_cs    = 1'b1;
        gfx_addr  = g;
        main_cs   = 1'b1;
        main_addr = m;
        #2;
        n = 0;
        while (!(gfx_ok && main_ok) && n < TIMEOUT) begin
            @(negedge clk);
            #2;
            n++;
        end
        if (!(gfx_ok && main_ok)) report_failure("both slots did not reach ok");
        check_value("gfx_data", model_word(`GFX_OFFSET + g), gfx_data);
        check_value("main_data", model_byte(m), main_data);
        if (rd_addrs.size() > n0) begin
            check_value("sdram_addr", (`GFX_OFFSET + g) & ~`SDRAM_AW'(1), rd_addrs[n0]);
        end else begin
            report_failure("no SDRAM read for two misses");
        end
        @(negedge clk);
        gfx_cs  = 1'b0;
        main_cs = 1'b0;
        end_test("arbitration");

        begin_test();
        n0 = rd_addrs.size();
        @(negedge clk);
        downloading = 1'b1;
        main_cs     = 1'b1;
        main_addr   = m ^ 17'h40;   // Miss held off by the download
        repeat (4) @(negedge clk);
        main_cs = 1'b0;
        load_byte(25'h0_0042, 8'h99);
        if (rd_addrs.size() != n0) report_failure("read issued while downloading");
        @(negedge clk);
        downloading = 1'b0;
        repeat (2) @(negedge clk);   // Flush lands
        read_slot(1'b0, m, lat);
        if (rd_addrs.size() == n0) report_failure("cached line survived the download");
        end_test("download interlock");

        @(negedge clk);
        $display("tests %0d, failed tests %0d, check errors %0d, assertion errors %0d",
                 tests, failed_tests, errors, u_dut.u_sva.fail_cnt);
        if (total_errors() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+rtl
rtl/sdram_pkg.sv
rtl/prog_pkg.sv
rtl/rom_slot.sv
rtl/rom_req_ctrl.sv
rtl/rom_dwnld.sv
rtl/game_rom.sv
verification/game_rom_sva.sv
verification/tb_game_rom.sv
